//--- compile.f
verilog/tomasulo_pkg.sv
verilog/reg_status_table.sv
verilog/reg_file.sv
verilog/dispatch_decode.sv
verilog/reservation_station.sv
verilog/alu_pipe.sv
verilog/tomasulo_core.sv
tb/tomasulo_tb.sv

//--- tb/tomasulo_tb.sv
`default_nettype none

module tomasulo_tb;

   timeunit 1ns;
   timeprecision 1ps;

   import tomasulo_pkg::*;

   localparam int max_rows    = 64;
   localparam int n_regs      = 2 ** reg_addr_bits;
   localparam int n_tags      = 2 ** tag_bits;
   localparam int stall_limit = 100;
   localparam int idle_limit  = 500;

   // DUT ports.
   logic      clk;
   logic      rst;
   logic      instr_valid;
   alu_op_t   instr_op;
   reg_addr_t instr_rd;
   reg_addr_t instr_rs;
   reg_addr_t instr_rt;
   data_t     instr_imm;
   logic      instr_stall;
   logic      cdb_valid;
   tag_t      cdb_tag;
   data_t     cdb_data;
   reg_addr_t rd_addr;
   data_t     rd_data;
   logic      rd_busy;
   logic      core_idle;

   // Instruction table with the expected result of every row.
   // Burst rows are sent back to back with no idle gap.
   alu_op_t   row_op    [max_rows];
   reg_addr_t row_rd    [max_rows];
   reg_addr_t row_rs    [max_rows];
   reg_addr_t row_rt    [max_rows];
   data_t     row_imm   [max_rows];
   data_t     row_exp   [max_rows];
   bit        row_burst [max_rows];
   int        n_rows;

   // Sequential reference model of the register file.
   data_t model_regs [n_regs];

   // Tags that were handed out and whose result is not yet on the bus.
   bit outstanding [n_tags];
   int tag_row     [n_tags];
   int n_accepted;
   int new_tag;

   bit saw_stall;
   int seed_value;

   tomasulo_core dut0 (
      .clk         (clk),
      .rst         (rst),
      .instr_valid (instr_valid),
      .instr_op    (instr_op),
      .instr_rd    (instr_rd),
      .instr_rs    (instr_rs),
      .instr_rt    (instr_rt),
      .instr_imm   (instr_imm),
      .instr_stall (instr_stall),
      .cdb_valid   (cdb_valid),
      .cdb_tag     (cdb_tag),
      .cdb_data    (cdb_data),
      .rd_addr     (rd_addr),
      .rd_data     (rd_data),
      .rd_busy     (rd_busy),
      .core_idle   (core_idle)
   );

   always begin
      #5 clk = ~clk;
   end

   // Result of one instruction executed in program order.
   function automatic data_t alu_model(input alu_op_t op, input data_t a, input data_t b,
                                       input data_t imm);
      case (op)
         op_li:   return imm;
         op_add:  return a + b;
         op_sub:  return a - b;
         op_and:  return a & b;
         op_or:   return a | b;
         op_xor:  return a ^ b;
         default: return '0;
      endcase
   endfunction

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("ERROR at %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
         $display("TEST FAIL");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("TEST FAIL");
      $fatal(1, "run aborted");
   endtask

   // Appends one row and advances the model, so every row knows its result.
   task automatic add_row(input alu_op_t op, input int rd, input int rs, input int rt,
                          input bit burst);
      data_t imm;
      imm = data_t'($urandom);
      row_op[n_rows]    = op;
      row_rd[n_rows]    = reg_addr_t'(rd);
      row_rs[n_rows]    = reg_addr_t'(rs);
      row_rt[n_rows]    = reg_addr_t'(rt);
      row_imm[n_rows]   = imm;
      row_burst[n_rows] = burst;
      row_exp[n_rows]   = alu_model(op, model_regs[rs], model_regs[rt], imm);
      model_regs[rd]    = row_exp[n_rows];
      n_rows++;
   endtask

   task automatic build_program();
      // Loads and independent rows with one of each operation.
      add_row(op_li,  1, 0, 0, 0);
      add_row(op_li,  2, 0, 0, 0);
      add_row(op_li,  3, 0, 0, 0);
      add_row(op_add, 4, 1, 2, 0);
      add_row(op_sub, 5, 1, 2, 0);
      add_row(op_and, 6, 2, 3, 0);
      add_row(op_or,  7, 1, 3, 0);
      add_row(op_xor, 0, 2, 3, 0);
      // Read-after-write chain where each row reads the one before it.
      add_row(op_add, 1, 1, 2, 0);
      add_row(op_sub, 2, 1, 3, 0);
      add_row(op_xor, 3, 2, 1, 0);
      add_row(op_or,  4, 3, 2, 0);
      add_row(op_and, 5, 4, 3, 0);
      add_row(op_add, 6, 5, 5, 0);
      // Write-after-write on r7.
      // The last write must survive.
      add_row(op_li,  7, 0, 0, 0);
      add_row(op_li,  7, 0, 0, 0);
      add_row(op_add, 7, 7, 1, 0);
      // Long dependent burst that fills every entry.
      add_row(op_add, 1, 1, 2, 1);
      add_row(op_add, 2, 1, 1, 1);
      add_row(op_add, 3, 2, 1, 1);
      add_row(op_sub, 4, 3, 2, 1);
      add_row(op_xor, 5, 4, 1, 1);
      add_row(op_or,  6, 5, 3, 1);
      // The slow add to r5 is overtaken by the load to r5 behind it.
      add_row(op_add, 5, 6, 6, 1);
      add_row(op_li,  5, 0, 0, 1);
      add_row(op_add, 0, 5, 5, 1);
      add_row(op_and, 3, 0, 6, 0);
      add_row(op_sub, 4, 7, 3, 0);
   endtask

   // Waits on falling edges until a free entry is reported.
   task automatic wait_stall_low();
      int count;
      count = 0;
      while (instr_stall) begin
         if (count >= stall_limit) begin
            fail_run("Timed out waiting for instr_stall to go low.");
         end
         @(negedge clk);
         count++;
      end
   endtask

   task automatic wait_idle();
      int count;
      count = 0;
      while (!core_idle) begin
         if (count >= idle_limit) begin
            fail_run("Timed out waiting for core_idle after the last instruction.");
         end
         @(negedge clk);
         count++;
      end
   endtask

   // The stall level is stable from the falling edge on, so the row is
   // taken at the rising edge that follows.
   task automatic send_row(input int idx);
      int gap;
      gap = row_burst[idx] ? 0 : int'($urandom % 3);
      instr_valid = 1'b0;
      repeat (gap) @(negedge clk);
      wait_stall_low();
      instr_valid = 1'b1;
      instr_op    = row_op[idx];
      instr_rd    = row_rd[idx];
      instr_rs    = row_rs[idx];
      instr_rt    = row_rt[idx];
      instr_imm   = row_imm[idx];
      @(negedge clk);
      instr_valid = 1'b0;
   endtask

   task automatic check_regs(input bit use_model);
      data_t expected;
      for (int i = 0; i < n_regs; i++) begin
         @(negedge clk);
         rd_addr  = reg_addr_t'(i);
         expected = use_model ? model_regs[i] : '0;
         #1;
         check_value(rd_data, expected, $sformatf("value of r%0d", i));
         check_value(rd_busy, 1'b0, $sformatf("busy bit of r%0d", i));
      end
   endtask

   // Bus monitor.
   // Acceptance is handled first, because a tag on the bus in this cycle
   // is still taken when the new tag is chosen.
   always @(posedge clk) begin
      if (!rst) begin
         if (instr_stall) begin
            saw_stall = 1'b1;
         end
         if (instr_valid && !instr_stall) begin
            new_tag = -1;
            for (int t = n_tags - 1; t >= 0; t--) begin
               if (!outstanding[t]) begin
                  new_tag = t;
               end
            end
            if (new_tag < 0) begin
               fail_run("An instruction was accepted while every tag was outstanding.");
            end
            outstanding[new_tag] = 1'b1;
            tag_row[new_tag]     = n_accepted;
            n_accepted++;
         end
         if (cdb_valid) begin
            if (!outstanding[cdb_tag]) begin
               fail_run($sformatf("The bus carried tag %0d, which was not outstanding.",
                                  cdb_tag));
            end
            check_value(cdb_data, row_exp[tag_row[cdb_tag]],
                        $sformatf("bus data of row %0d", tag_row[cdb_tag]));
            outstanding[cdb_tag] = 1'b0;
         end
      end
   end

   initial begin
      clk         = 1'b0;
      rst         = 1'b1;
      instr_valid = 1'b0;
      instr_op    = op_li;
      instr_rd    = '0;
      instr_rs    = '0;
      instr_rt    = '0;
      instr_imm   = '0;
      rd_addr     = '0;
      n_rows      = 0;
      n_accepted  = 0;
      saw_stall   = 1'b0;
      for (int t = 0; t < n_tags; t++) begin
         outstanding[t] = 1'b0;
         tag_row[t]     = 0;
      end
      for (int i = 0; i < n_regs; i++) begin
         model_regs[i] = '0;
      end
      seed_value = $urandom(22724);
      build_program();

      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      // State right after reset.
      check_value(instr_stall, 1'b0, "instr_stall after reset");
      check_value(cdb_valid, 1'b0, "cdb_valid after reset");
      check_value(core_idle, 1'b1, "core_idle after reset");
      check_regs(1'b0);

      @(negedge clk);
      for (int i = 0; i < n_rows; i++) begin
         send_row(i);
      end
      wait_idle();

      for (int t = 0; t < n_tags; t++) begin
         check_value(outstanding[t], 1'b0, $sformatf("result of tag %0d never broadcast", t));
      end
      check_value(saw_stall, 1'b1, "instr_stall seen high during the burst");
      check_regs(1'b1);

      $display("TEST PASS");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog/tomasulo_core.sv
`default_nettype none

module tomasulo_core #(
   parameter int W_ADDR = tomasulo_pkg::reg_addr_bits,
   parameter int W_TAG  = tomasulo_pkg::tag_bits,
   parameter int W_DATA = tomasulo_pkg::data_bits
) (
   input  logic                  clk,
   input  logic                  rst,

   input  logic                  instr_valid,
   input  tomasulo_pkg::alu_op_t instr_op,
   input  logic [W_ADDR-1:0]     instr_rd,
   input  logic [W_ADDR-1:0]     instr_rs,
   input  logic [W_ADDR-1:0]     instr_rt,
   input  logic [W_DATA-1:0]     instr_imm,
   output logic                  instr_stall,

   output logic                  cdb_valid,
   output logic [W_TAG-1:0]      cdb_tag,
   output logic [W_DATA-1:0]     cdb_data,

   // Architectural state for observation.
   input  logic [W_ADDR-1:0]     rd_addr,
   output logic [W_DATA-1:0]     rd_data,
   output logic                  rd_busy,
   output logic                  core_idle
);

   import tomasulo_pkg::*;

   // Decode to rename and register file.
   logic [W_ADDR-1:0] rs_addr;
   logic [W_ADDR-1:0] rt_addr;
   logic [W_TAG-1:0]  rs_tag;
   logic [W_TAG-1:0]  rt_tag;
   logic              rs_busy;
   logic              rt_busy;
   logic [W_DATA-1:0] rs_value;
   logic [W_DATA-1:0] rt_value;
   logic [W_ADDR-1:0] alloc_addr;
   logic [W_TAG-1:0]  alloc_tag;
   logic              alloc_valid;
   logic [2**W_ADDR-1:0] regfile_wen_onehot;

   // Decode to reservation station.
   logic              ent_valid;
   alu_op_t           ent_op;
   logic [W_TAG-1:0]  ent_tag;
   logic [W_DATA-1:0] ent_a_value;
   logic [W_TAG-1:0]  ent_a_tag;
   logic              ent_a_ready;
   logic [W_DATA-1:0] ent_b_value;
   logic [W_TAG-1:0]  ent_b_tag;
   logic              ent_b_ready;
   logic [W_DATA-1:0] ent_imm;
   logic [W_TAG-1:0]  free_tag;

   // Reservation station to ALU.
   logic              issue_valid;
   alu_op_t           issue_op;
   logic [W_TAG-1:0]  issue_tag;
   logic [W_DATA-1:0] issue_a;
   logic [W_DATA-1:0] issue_b;
   logic [W_DATA-1:0] issue_imm;
   logic              rs_idle;

   dispatch_decode #(.W_ADDR(W_ADDR), .W_TAG(W_TAG), .W_DATA(W_DATA)) u_decode (
      .instr_valid (instr_valid),  .instr_op    (instr_op),
      .instr_rd    (instr_rd),     .instr_rs    (instr_rs),
      .instr_rt    (instr_rt),     .instr_imm   (instr_imm),
      .instr_stall (instr_stall),  .free_tag    (free_tag),
      .rs_addr     (rs_addr),      .rt_addr     (rt_addr),
      .rs_tag      (rs_tag),       .rs_busy     (rs_busy),
      .rt_tag      (rt_tag),       .rt_busy     (rt_busy),
      .rs_value    (rs_value),     .rt_value    (rt_value),
      .cdb_valid   (cdb_valid),    .cdb_tag     (cdb_tag),
      .cdb_data    (cdb_data),
      .alloc_addr  (alloc_addr),   .alloc_tag   (alloc_tag),
      .alloc_valid (alloc_valid),
      .ent_valid   (ent_valid),    .ent_op      (ent_op),
      .ent_tag     (ent_tag),
      .ent_a_value (ent_a_value),  .ent_a_tag   (ent_a_tag),
      .ent_a_ready (ent_a_ready),
      .ent_b_value (ent_b_value),  .ent_b_tag   (ent_b_tag),
      .ent_b_ready (ent_b_ready),  .ent_imm     (ent_imm)
   );

   reg_status_table #(.W_ADDR(W_ADDR), .W_TAG(W_TAG)) u_status (
      .clk         (clk),          .rst         (rst),
      .rs_addr     (rs_addr),      .rt_addr     (rt_addr),
      .rs_tag      (rs_tag),       .rs_busy     (rs_busy),
      .rt_tag      (rt_tag),       .rt_busy     (rt_busy),
      .rd_addr     (rd_addr),      .rd_busy     (rd_busy),
      .alloc_addr  (alloc_addr),   .alloc_tag   (alloc_tag),
      .alloc_valid (alloc_valid),
      .cdb_tag     (cdb_tag),      .cdb_valid   (cdb_valid),
      .regfile_wen_onehot (regfile_wen_onehot)
   );

   reg_file #(.W_ADDR(W_ADDR), .W_DATA(W_DATA)) u_regs (
      .clk         (clk),          .rst         (rst),
      .rs_addr     (rs_addr),      .rt_addr     (rt_addr),
      .rd_addr     (rd_addr),
      .rs_value    (rs_value),     .rt_value    (rt_value),
      .rd_data     (rd_data),
      .regfile_wen_onehot (regfile_wen_onehot),
      .cdb_data    (cdb_data)
   );

   reservation_station #(.W_TAG(W_TAG), .W_DATA(W_DATA)) u_station (
      .clk         (clk),          .rst         (rst),
      .ent_valid   (ent_valid),    .ent_op      (ent_op),
      .ent_tag     (ent_tag),
      .ent_a_value (ent_a_value),  .ent_a_tag   (ent_a_tag),
      .ent_a_ready (ent_a_ready),
      .ent_b_value (ent_b_value),  .ent_b_tag   (ent_b_tag),
      .ent_b_ready (ent_b_ready),  .ent_imm     (ent_imm),
      .cdb_valid   (cdb_valid),    .cdb_tag     (cdb_tag),
      .cdb_data    (cdb_data),
      .instr_stall (instr_stall),  .free_tag    (free_tag),
      .issue_valid (issue_valid),  .issue_op    (issue_op),
      .issue_tag   (issue_tag),    .issue_a     (issue_a),
      .issue_b     (issue_b),      .issue_imm   (issue_imm),
      .rs_idle     (rs_idle)
   );

   alu_pipe #(.W_TAG(W_TAG), .W_DATA(W_DATA)) u_alu (
      .clk         (clk),          .rst         (rst),
      .issue_valid (issue_valid),  .issue_op    (issue_op),
      .issue_tag   (issue_tag),    .issue_a     (issue_a),
      .issue_b     (issue_b),      .issue_imm   (issue_imm),
      .rs_idle     (rs_idle),
      .cdb_valid   (cdb_valid),    .cdb_tag     (cdb_tag),
      .cdb_data    (cdb_data),     .core_idle   (core_idle)
   );

endmodule

`default_nettype wire

//--- verilog/alu_pipe.sv
`default_nettype none

module alu_pipe #(
   parameter int W_TAG  = tomasulo_pkg::tag_bits,
   parameter int W_DATA = tomasulo_pkg::data_bits
) (
   input  logic                  clk,
   input  logic                  rst,

   // Issue from the reservation station.
   input  logic                  issue_valid,
   input  tomasulo_pkg::alu_op_t issue_op,
   input  logic [W_TAG-1:0]      issue_tag,
   input  logic [W_DATA-1:0]     issue_a,
   input  logic [W_DATA-1:0]     issue_b,
   input  logic [W_DATA-1:0]     issue_imm,
   input  logic                  rs_idle,

   // Common data bus.
   output logic                  cdb_valid,
   output logic [W_TAG-1:0]      cdb_tag,
   output logic [W_DATA-1:0]     cdb_data,
   output logic                  core_idle
);

   import tomasulo_pkg::*;

   // Stage one holds the operands.
   logic              s1_valid;
   alu_op_t           s1_op;
   logic [W_TAG-1:0]  s1_tag;
   logic [W_DATA-1:0] s1_a;
   logic [W_DATA-1:0] s1_b;
   logic [W_DATA-1:0] s1_imm;
   logic [W_DATA-1:0] s1_result;

   always_ff @(posedge clk) begin
      if (rst) begin
         s1_valid <= 1'b0;
      end else begin
         s1_valid <= issue_valid;
      end
   end

   always_ff @(posedge clk) begin
      s1_op  <= issue_op;
      s1_tag <= issue_tag;
      s1_a   <= issue_a;
      s1_b   <= issue_b;
      s1_imm <= issue_imm;
   end

   always_comb begin
      case (s1_op)
         op_li:   s1_result = s1_imm;
         op_add:  s1_result = s1_a + s1_b;
         op_sub:  s1_result = s1_a - s1_b;
         op_and:  s1_result = s1_a & s1_b;
         op_or:   s1_result = s1_a | s1_b;
         op_xor:  s1_result = s1_a ^ s1_b;
         default: s1_result = '0;
      endcase
   end

   // Stage two is the bus itself.
   // One result per cycle at most, so the bus never needs arbitration.
   always_ff @(posedge clk) begin
      if (rst) begin
         cdb_valid <= 1'b0;
      end else begin
         cdb_valid <= s1_valid;
      end
   end

   always_ff @(posedge clk) begin
      cdb_tag  <= s1_tag;
      cdb_data <= s1_result;
   end

   assign core_idle = rs_idle && !s1_valid && !cdb_valid;

endmodule

`default_nettype wire

//--- verilog/reservation_station.sv
`default_nettype none

module reservation_station #(
   parameter int W_TAG  = tomasulo_pkg::tag_bits,
   parameter int W_DATA = tomasulo_pkg::data_bits
) (
   input  logic                  clk,
   input  logic                  rst,

   // Entry write from decode.
   input  logic                  ent_valid,
   input  tomasulo_pkg::alu_op_t ent_op,
   input  logic [W_TAG-1:0]      ent_tag,
   input  logic [W_DATA-1:0]     ent_a_value,
   input  logic [W_TAG-1:0]      ent_a_tag,
   input  logic                  ent_a_ready,
   input  logic [W_DATA-1:0]     ent_b_value,
   input  logic [W_TAG-1:0]      ent_b_tag,
   input  logic                  ent_b_ready,
   input  logic [W_DATA-1:0]     ent_imm,

   // Common data bus.
   input  logic                  cdb_valid,
   input  logic [W_TAG-1:0]      cdb_tag,
   input  logic [W_DATA-1:0]     cdb_data,

   output logic                  instr_stall,
   output logic [W_TAG-1:0]      free_tag,

   // Registered issue to the ALU.
   output logic                  issue_valid,
   output tomasulo_pkg::alu_op_t issue_op,
   output logic [W_TAG-1:0]      issue_tag,
   output logic [W_DATA-1:0]     issue_a,
   output logic [W_DATA-1:0]     issue_b,
   output logic [W_DATA-1:0]     issue_imm,
   output logic                  rs_idle
);

   import tomasulo_pkg::*;

   localparam int n_ent = 2 ** W_TAG;

   // Control state of each entry.
   // An entry leaves the issue pool at issue, but its tag stays taken
   // until the result is broadcast, so no new instruction reuses it early.
   logic [n_ent-1:0] busy_q;
   logic [n_ent-1:0] pending_q;
   logic [n_ent-1:0] a_rdy_q;
   logic [n_ent-1:0] b_rdy_q;

   // Payload of each entry.
   alu_op_t           op_q    [n_ent];
   logic [W_DATA-1:0] a_val_q [n_ent];
   logic [W_TAG-1:0]  a_tag_q [n_ent];
   logic [W_DATA-1:0] b_val_q [n_ent];
   logic [W_TAG-1:0]  b_tag_q [n_ent];
   logic [W_DATA-1:0] imm_q   [n_ent];

   logic [n_ent-1:0] ready_vec;
   logic [n_ent-1:0] free_vec;
   logic [W_TAG-1:0] issue_idx;

   assign ready_vec   = busy_q & a_rdy_q & b_rdy_q;
   assign free_vec    = ~(busy_q | pending_q);
   assign instr_stall = ~|free_vec;

   // Priority encoders.
   // Scanning downwards leaves the lowest set index.
   always_comb begin
      issue_idx = '0;
      free_tag  = '0;
      for (int i = n_ent - 1; i >= 0; i--) begin
         if (ready_vec[i]) begin
            issue_idx = W_TAG'(i);
         end
         if (free_vec[i]) begin
            free_tag = W_TAG'(i);
         end
      end
   end

   // Entry control.
   // Operands captured at an edge count as ready from that edge on.
   always_ff @(posedge clk) begin
      for (int i = 0; i < n_ent; i++) begin
         if (rst) begin
            busy_q[i]    <= 1'b0;
            pending_q[i] <= 1'b0;
         end else if (ent_valid && (ent_tag == W_TAG'(i))) begin
            busy_q[i]  <= 1'b1;
            a_rdy_q[i] <= ent_a_ready;
            b_rdy_q[i] <= ent_b_ready;
         end else if (ready_vec[i] && (issue_idx == W_TAG'(i))) begin
            busy_q[i]    <= 1'b0;
            pending_q[i] <= 1'b1;
         end else begin
            // Waiting slots snoop the bus.
            if (busy_q[i] && !a_rdy_q[i] && cdb_valid && (a_tag_q[i] == cdb_tag)) begin
               a_rdy_q[i] <= 1'b1;
            end
            if (busy_q[i] && !b_rdy_q[i] && cdb_valid && (b_tag_q[i] == cdb_tag)) begin
               b_rdy_q[i] <= 1'b1;
            end
            // The broadcast of this entry's own result frees its tag.
            if (pending_q[i] && cdb_valid && (cdb_tag == W_TAG'(i))) begin
               pending_q[i] <= 1'b0;
            end
         end
      end
   end

   // Entry payload.
   always_ff @(posedge clk) begin
      for (int i = 0; i < n_ent; i++) begin
         if (ent_valid && (ent_tag == W_TAG'(i))) begin
            op_q[i]    <= ent_op;
            a_val_q[i] <= ent_a_value;
            a_tag_q[i] <= ent_a_tag;
            b_val_q[i] <= ent_b_value;
            b_tag_q[i] <= ent_b_tag;
            imm_q[i]   <= ent_imm;
         end else begin
            if (!a_rdy_q[i] && cdb_valid && (a_tag_q[i] == cdb_tag)) begin
               a_val_q[i] <= cdb_data;
            end
            if (!b_rdy_q[i] && cdb_valid && (b_tag_q[i] == cdb_tag)) begin
               b_val_q[i] <= cdb_data;
            end
         end
      end
   end

   // Issue register.
   // The ALU latches it one cycle later as its first stage.
   always_ff @(posedge clk) begin
      if (rst) begin
         issue_valid <= 1'b0;
      end else begin
         issue_valid <= |ready_vec;
      end
   end

   always_ff @(posedge clk) begin
      issue_op  <= op_q[issue_idx];
      issue_tag <= issue_idx;
      issue_a   <= a_val_q[issue_idx];
      issue_b   <= b_val_q[issue_idx];
      issue_imm <= imm_q[issue_idx];
   end

   // Work in the issue register is not yet visible to the ALU.
   assign rs_idle = ~|busy_q && !issue_valid;

endmodule

`default_nettype wire

//--- verilog/dispatch_decode.sv
`default_nettype none

module dispatch_decode #(
   parameter int W_ADDR = tomasulo_pkg::reg_addr_bits,
   parameter int W_TAG  = tomasulo_pkg::tag_bits,
   parameter int W_DATA = tomasulo_pkg::data_bits
) (
   // Incoming instruction.
   input  logic                  instr_valid,
   input  tomasulo_pkg::alu_op_t instr_op,
   input  logic [W_ADDR-1:0]     instr_rd,
   input  logic [W_ADDR-1:0]     instr_rs,
   input  logic [W_ADDR-1:0]     instr_rt,
   input  logic [W_DATA-1:0]     instr_imm,
   input  logic                  instr_stall,
   input  logic [W_TAG-1:0]      free_tag,

   // Rename and register reads.
   output logic [W_ADDR-1:0]     rs_addr,
   output logic [W_ADDR-1:0]     rt_addr,
   input  logic [W_TAG-1:0]      rs_tag,
   input  logic                  rs_busy,
   input  logic [W_TAG-1:0]      rt_tag,
   input  logic                  rt_busy,
   input  logic [W_DATA-1:0]     rs_value,
   input  logic [W_DATA-1:0]     rt_value,

   // Common data bus, for the same-cycle bypass.
   input  logic                  cdb_valid,
   input  logic [W_TAG-1:0]      cdb_tag,
   input  logic [W_DATA-1:0]     cdb_data,

   // Rename write.
   output logic [W_ADDR-1:0]     alloc_addr,
   output logic [W_TAG-1:0]      alloc_tag,
   output logic                  alloc_valid,

   // New reservation-station entry.
   output logic                  ent_valid,
   output tomasulo_pkg::alu_op_t ent_op,
   output logic [W_TAG-1:0]      ent_tag,
   output logic [W_DATA-1:0]     ent_a_value,
   output logic [W_TAG-1:0]      ent_a_tag,
   output logic                  ent_a_ready,
   output logic [W_DATA-1:0]     ent_b_value,
   output logic [W_TAG-1:0]      ent_b_tag,
   output logic                  ent_b_ready,
   output logic [W_DATA-1:0]     ent_imm
);

   import tomasulo_pkg::*;

   logic accept;
   logic is_li;

   // Ready bit on top, then the operand value.
   logic [W_DATA:0] a_res;
   logic [W_DATA:0] b_res;

   // An operand is ready if its register is not pending.
   // It is also ready if its producer broadcasts in this very cycle,
   // since the status table only clears after the edge.
   function automatic logic [W_DATA:0] resolve(
      input logic              busy,
      input logic [W_TAG-1:0]  tag,
      input logic [W_DATA-1:0] value,
      input logic              bus_valid,
      input logic [W_TAG-1:0]  bus_tag,
      input logic [W_DATA-1:0] bus_data
   );
      if (!busy) begin
         return {1'b1, value};
      end
      if (bus_valid && (bus_tag == tag)) begin
         return {1'b1, bus_data};
      end
      return {1'b0, value};
   endfunction

   assign accept = instr_valid && !instr_stall;
   assign is_li  = (instr_op == op_li);

   assign rs_addr = instr_rs;
   assign rt_addr = instr_rt;

   // Load immediate needs no sources.
   // Both slots start ready and the ALU takes the immediate.
   always_comb begin
      a_res = resolve(rs_busy, rs_tag, rs_value, cdb_valid, cdb_tag, cdb_data);
      b_res = resolve(rt_busy, rt_tag, rt_value, cdb_valid, cdb_tag, cdb_data);
      if (is_li) begin
         a_res = {1'b1, {W_DATA{1'b0}}};
         b_res = {1'b1, {W_DATA{1'b0}}};
      end
   end

   // The destination is renamed to the lowest free entry.
   assign alloc_addr  = instr_rd;
   assign alloc_tag   = free_tag;
   assign alloc_valid = accept;

   assign ent_valid   = accept;
   assign ent_op      = instr_op;
   assign ent_tag     = free_tag;
   assign ent_a_ready = a_res[W_DATA];
   assign ent_a_value = a_res[W_DATA-1:0];
   assign ent_a_tag   = rs_tag;
   assign ent_b_ready = b_res[W_DATA];
   assign ent_b_value = b_res[W_DATA-1:0];
   assign ent_b_tag   = rt_tag;
   assign ent_imm     = instr_imm;

endmodule

`default_nettype wire

//--- verilog/reg_file.sv
`default_nettype none

module reg_file #(
   parameter int W_ADDR = tomasulo_pkg::reg_addr_bits,
   parameter int W_DATA = tomasulo_pkg::data_bits
) (
   input  logic                 clk,
   input  logic                 rst,

   // Source reads for decode and one read for the outside.
   input  logic [W_ADDR-1:0]    rs_addr,
   input  logic [W_ADDR-1:0]    rt_addr,
   input  logic [W_ADDR-1:0]    rd_addr,
   output logic [W_DATA-1:0]    rs_value,
   output logic [W_DATA-1:0]    rt_value,
   output logic [W_DATA-1:0]    rd_data,

   // Write-back from the common data bus.
   input  logic [2**W_ADDR-1:0] regfile_wen_onehot,
   input  logic [W_DATA-1:0]    cdb_data
);

   localparam int n_regs = 2 ** W_ADDR;

   logic [W_DATA-1:0] regs_q [n_regs];

   // Reads are asynchronous.
   // A value written at an edge is seen by decode in the next cycle.
   assign rs_value = regs_q[rs_addr];
   assign rt_value = regs_q[rt_addr];
   assign rd_data  = regs_q[rd_addr];

   // Architectural state starts at zero.
   // Every register selected by the status table takes the bus data.
   always_ff @(posedge clk) begin
      for (int i = 0; i < n_regs; i++) begin
         if (rst) begin
            regs_q[i] <= '0;
         end else if (regfile_wen_onehot[i]) begin
            regs_q[i] <= cdb_data;
         end
      end
   end

endmodule

`default_nettype wire

//--- verilog/reg_status_table.sv
`default_nettype none

module reg_status_table #(
   parameter int W_ADDR = tomasulo_pkg::reg_addr_bits,
   parameter int W_TAG  = tomasulo_pkg::tag_bits
) (
   input  logic                   clk,
   input  logic                   rst,

   // Rename lookups for the two sources of the instruction in decode.
   input  logic [W_ADDR-1:0]      rs_addr,
   input  logic [W_ADDR-1:0]      rt_addr,
   output logic [W_TAG-1:0]       rs_tag,
   output logic                   rs_busy,
   output logic [W_TAG-1:0]       rt_tag,
   output logic                   rt_busy,

   // External status port.
   input  logic [W_ADDR-1:0]      rd_addr,
   output logic                   rd_busy,

   // Allocation by decode.
   input  logic [W_ADDR-1:0]      alloc_addr,
   input  logic [W_TAG-1:0]       alloc_tag,
   input  logic                   alloc_valid,

   // Broadcast from the common data bus.
   input  logic [W_TAG-1:0]       cdb_tag,
   input  logic                   cdb_valid,

   output logic [2**W_ADDR-1:0]   regfile_wen_onehot
);

   localparam int n_regs = 2 ** W_ADDR;

   // One pending tag and one busy bit per architectural register.
   logic [W_TAG-1:0]  tag_q [n_regs];
   logic [n_regs-1:0] busy_q;

   // Registers whose pending tag matches the tag on the bus.
   logic [n_regs-1:0] cdb_hit;

   // All lookups read the registered state.
   // A dispatch in this cycle becomes visible after the edge.
   assign rs_tag  = tag_q[rs_addr];
   assign rs_busy = busy_q[rs_addr];
   assign rt_tag  = tag_q[rt_addr];
   assign rt_busy = busy_q[rt_addr];
   assign rd_busy = busy_q[rd_addr];

   // Content-addressable search over all registers.
   // Only busy registers take part, so a stale tag left in an idle
   // register never matches.
   // At most one register holds a given tag, because a later dispatch
   // to another register with the same tag can only happen after the
   // broadcast that retires it.
   // After a write-after-write the older tag is gone from the table and
   // its broadcast simply finds nothing.
   always_comb begin
      for (int i = 0; i < n_regs; i++) begin
         cdb_hit[i] = cdb_valid && busy_q[i] && (tag_q[i] == cdb_tag);
      end
   end

   // The register file takes the bus data wherever the tag was found.
   assign regfile_wen_onehot = cdb_hit;

   // Busy bits.
   // A dispatch to a register wins over a broadcast that clears it.
   always_ff @(posedge clk) begin
      for (int i = 0; i < n_regs; i++) begin
         if (rst) begin
            busy_q[i] <= 1'b0;
         end else if (alloc_valid && (alloc_addr == W_ADDR'(i))) begin
            busy_q[i] <= 1'b1;
         end else if (cdb_hit[i]) begin
            busy_q[i] <= 1'b0;
         end
      end
   end

   // Tags only change on allocation.
   // The busy bit says whether a tag means anything.
   always_ff @(posedge clk) begin
      for (int i = 0; i < n_regs; i++) begin
         if (alloc_valid && (alloc_addr == W_ADDR'(i))) begin
            tag_q[i] <= alloc_tag;
         end
      end
   end

endmodule

`default_nettype wire

//--- verilog/tomasulo_pkg.sv
`default_nettype none

// Widths and types shared by the Tomasulo core and its testbench.
package tomasulo_pkg;

   // Eight architectural registers.
   localparam int reg_addr_bits = 3;

   // Four reservation-station entries.
   // A tag is the index of the entry that produces the value.
   localparam int tag_bits = 2;

   // Width of every data word on the bus and in the register file.
   localparam int data_bits = 16;

   typedef logic [reg_addr_bits-1:0] reg_addr_t;
   typedef logic [tag_bits-1:0]      tag_t;
   typedef logic [data_bits-1:0]     data_t;

   // Operations of the single integer ALU.
   // Load immediate ignores both source registers.
   typedef enum logic [2:0] {
      op_li  = 3'd0,
      op_add = 3'd1,
      op_sub = 3'd2,
      op_and = 3'd3,
      op_or  = 3'd4,
      op_xor = 3'd5
   } alu_op_t;

endpackage

`default_nettype wire
